// File: hdl/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// RV32I ALU with branch compare flags
// ******************************

module rv_alu
   import rv_pkg::*;
(
   input  wire word_t   i_a,
   input  wire word_t   i_b,
   input  wire alu_fn_e i_fn,
   output word_t        o_result,
   output logic         o_zero,
   output logic         o_lt,
   output logic         o_ltu
);

   logic [4:0] shamt;

   assign shamt = i_b[4:0];

   // Flags do not depend on the function code
   assign o_zero = (i_a == i_b);
   assign o_lt   = ($signed(i_a) < $signed(i_b));
   assign o_ltu  = (i_a < i_b);

   always_comb begin
      case (i_fn)
         ADD:     o_result = i_a + i_b;
         SUB:     o_result = i_a - i_b;
         SLL:     o_result = i_a << shamt;
         SLT:     o_result = {31'd0, o_lt};
         SLTU:    o_result = {31'd0, o_ltu};
         XOR:     o_result = i_a ^ i_b;
         SRL:     o_result = i_a >> shamt;
         SRA:     o_result = word_t'($signed(i_a) >>> shamt);
         OR:      o_result = i_a | i_b;
         AND:     o_result = i_a & i_b;
         default: o_result = i_a + i_b;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/rv_control.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// Multi-cycle control FSM
// Sequences boot, fetch, operand and load reads and writeback
// ******************************

module rv_control
   import rv_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst_n,
   output addr_t        o_addr,
   output logic         o_rd_en,
   input  wire word_t   i_rd_data,
   input  wire          i_rd_valid,
   output logic         o_wr_en,
   output word_t        o_wr_data,
   input  wire opcode_e i_opcode,
   input  wire [4:0]    i_rd,
   input  wire [4:0]    i_rs1,
   input  wire [4:0]    i_rs2,
   input  wire [2:0]    i_funct3,
   input  wire word_t   i_imm,
   input  wire          i_need_rs1,
   input  wire          i_need_rs2,
   input  wire          i_use_rs2,
   input  wire          i_legal,
   input  wire word_t   i_alu_result,
   input  wire          i_zero,
   input  wire          i_lt,
   input  wire          i_ltu,
   output logic         o_load_inst,
   output word_t        o_inst,
   output word_t        o_op_a,
   output word_t        o_op_b,
   output logic         o_fault
);

   state_e state;
   addr_t  pc;
   addr_t  pc_next;
   word_t  s1_data;
   word_t  s2_data;
   logic   s1_valid;
   logic   s2_valid;
   logic   s1_ok;
   logic   s2_ok;
   logic   taken;
   word_t  wb_data;
   word_t  ld_shift;
   word_t  ld_data;

   // Register n sits at byte address 4n
   function automatic addr_t reg_addr(input logic [4:0] idx);
      return {9'd0, idx, 2'b00};
   endfunction

   assign o_inst      = i_rd_data;
   assign o_load_inst = (state == WAIT_INST) && i_rd_valid;
   assign o_op_a      = s1_data;
   assign o_op_b      = i_use_rs2 ? s2_data : i_imm;
   assign o_fault     = (state == FAULT);

   // x0 is never read, its operand stays at the cleared zero
   assign s1_ok = !i_need_rs1 || s1_valid || (i_rs1 == 5'd0);
   assign s2_ok = !i_need_rs2 || s2_valid || (i_rs2 == 5'd0);

   always_comb begin
      case (i_funct3)
         3'b000:  taken = i_zero;
         3'b001:  taken = !i_zero;
         3'b100:  taken = i_lt;
         3'b101:  taken = !i_lt;
         3'b110:  taken = i_ltu;
         default: taken = !i_ltu;
      endcase
   end

   always_comb begin
      case (i_opcode)
         BRANCH:  pc_next = taken ? pc + i_imm[15:0] : pc + 16'd4;
         JAL:     pc_next = pc + i_imm[15:0];
         JALR:    pc_next = {i_alu_result[15:1], 1'b0};
         default: pc_next = pc + 16'd4;
      endcase
   end

   always_comb begin
      case (i_opcode)
         JAL, JALR: wb_data = {16'd0, pc + 16'd4};
         LUI:       wb_data = i_imm;
         default:   wb_data = i_alu_result;
      endcase
   end

   // Load address stays on o_addr until the data returns
   assign ld_shift = i_rd_data >> {o_addr[1:0], 3'b000};

   always_comb begin
      case (i_funct3)
         3'b000:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
         3'b001:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
         3'b100:  ld_data = {24'd0, ld_shift[7:0]};
         3'b101:  ld_data = {16'd0, ld_shift[15:0]};
         default: ld_data = i_rd_data;
      endcase
   end

   always_ff @(posedge clk) begin
      if (o_load_inst) begin
         s1_data <= '0;
         s2_data <= '0;
      end else if (i_rd_valid && state == WAIT_RS1) begin
         s1_data <= i_rd_data;
      end else if (i_rd_valid && state == WAIT_RS2) begin
         s2_data <= i_rd_data;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state     <= RESET_VEC;
         pc        <= '0;
         o_addr    <= '0;
         o_rd_en   <= 1'b0;
         o_wr_en   <= 1'b0;
         o_wr_data <= '0;
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
      end else begin
         o_rd_en <= 1'b0;
         o_wr_en <= 1'b0;
         case (state)
            RESET_VEC: begin
               o_addr  <= VEC_RESET;
               o_rd_en <= 1'b1;
               state   <= SP_VEC;
            end
            SP_VEC: if (i_rd_valid) begin
               pc      <= i_rd_data[15:0];
               o_addr  <= VEC_SP;
               o_rd_en <= 1'b1;
               state   <= SP_WR;
            end
            SP_WR: if (i_rd_valid) begin
               o_addr    <= reg_addr(SP_REG);
               o_wr_data <= i_rd_data;
               o_wr_en   <= 1'b1;
               state     <= WRITE;
            end
            // Fetch goes out right after a write
            FETCH, WRITE: begin
               o_addr  <= pc;
               o_rd_en <= 1'b1;
               state   <= WAIT_INST;
            end
            WAIT_INST: if (i_rd_valid) begin
               s1_valid <= 1'b0;
               s2_valid <= 1'b0;
               state    <= EXECUTE;
            end
            EXECUTE: begin
               if (!i_legal) begin
                  state <= FAULT;
               end else if (!s1_ok) begin
                  o_addr  <= reg_addr(i_rs1);
                  o_rd_en <= 1'b1;
                  state   <= WAIT_RS1;
               end else if (!s2_ok) begin
                  o_addr  <= reg_addr(i_rs2);
                  o_rd_en <= 1'b1;
                  state   <= WAIT_RS2;
               end else begin
                  pc <= pc_next;
                  case (i_opcode)
                     LOAD: begin
                        o_addr  <= i_alu_result[15:0];
                        o_rd_en <= 1'b1;
                        state   <= WAIT_LOAD;
                     end
                     STORE: begin
                        o_addr    <= i_alu_result[15:0];
                        o_wr_data <= s2_data;
                        o_wr_en   <= 1'b1;
                        state     <= WRITE;
                     end
                     BRANCH: state <= FETCH;
                     ALU_R, ALU_I, LUI, JAL, JALR: begin
                        if (i_rd != 5'd0) begin
                           o_addr    <= reg_addr(i_rd);
                           o_wr_data <= wb_data;
                           o_wr_en   <= 1'b1;
                           state     <= WRITE;
                        end else begin
                           state <= FETCH;
                        end
                     end
                     default: state <= FAULT;
                  endcase
               end
            end
            WAIT_RS1: if (i_rd_valid) begin
               s1_valid <= 1'b1;
               state    <= EXECUTE;
            end
            WAIT_RS2: if (i_rd_valid) begin
               s2_valid <= 1'b1;
               state    <= EXECUTE;
            end
            WAIT_LOAD: if (i_rd_valid) begin
               if (i_rd != 5'd0) begin
                  o_addr    <= reg_addr(i_rd);
                  o_wr_data <= ld_data;
                  o_wr_en   <= 1'b1;
                  state     <= WRITE;
               end else begin
                  state <= FETCH;
               end
            end
            // Sticky until reset
            default: state <= FAULT;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// RV32I subset core, registers held in external memory
// ******************************

module rv_core
   import rv_pkg::*;
(
   input  wire        clk,
   input  wire        i_rst_n,
   output addr_t      o_addr,
   output logic       o_rd_en,
   input  wire word_t i_rd_data,
   input  wire        i_rd_valid,
   output logic       o_wr_en,
   output word_t      o_wr_data,
   output logic       o_fault
);

   opcode_e    opcode;
   alu_fn_e    alu_fn;
   logic [4:0] rd;
   logic [4:0] rs1;
   logic [4:0] rs2;
   logic [2:0] funct3;
   word_t      imm;
   word_t      inst;
   word_t      op_a;
   word_t      op_b;
   word_t      alu_result;
   logic       need_rs1;
   logic       need_rs2;
   logic       use_rs2;
   logic       legal;
   logic       load_inst;
   logic       zero;
   logic       lt;
   logic       ltu;

   rv_control control_i (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .o_addr       (o_addr),
      .o_rd_en      (o_rd_en),
      .i_rd_data    (i_rd_data),
      .i_rd_valid   (i_rd_valid),
      .o_wr_en      (o_wr_en),
      .o_wr_data    (o_wr_data),
      .i_opcode     (opcode),
      .i_rd         (rd),
      .i_rs1        (rs1),
      .i_rs2        (rs2),
      .i_funct3     (funct3),
      .i_imm        (imm),
      .i_need_rs1   (need_rs1),
      .i_need_rs2   (need_rs2),
      .i_use_rs2    (use_rs2),
      .i_legal      (legal),
      .i_alu_result (alu_result),
      .i_zero       (zero),
      .i_lt         (lt),
      .i_ltu        (ltu),
      .o_load_inst  (load_inst),
      .o_inst       (inst),
      .o_op_a       (op_a),
      .o_op_b       (op_b),
      .o_fault      (o_fault)
   );

   rv_decoder decoder_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_load     (load_inst),
      .i_inst     (inst),
      .o_opcode   (opcode),
      .o_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .o_funct3   (funct3),
      .o_imm      (imm),
      .o_alu_fn   (alu_fn),
      .o_need_rs1 (need_rs1),
      .o_need_rs2 (need_rs2),
      .o_use_rs2  (use_rs2),
      .o_legal    (legal)
   );

   rv_alu alu_i (
      .i_a      (op_a),
      .i_b      (op_b),
      .i_fn     (alu_fn),
      .o_result (alu_result),
      .o_zero   (zero),
      .o_lt     (lt),
      .o_ltu    (ltu)
   );

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// Instruction register and field/immediate decoder
// ******************************

module rv_decoder
   import rv_pkg::*;
(
   input  wire         clk,
   input  wire         i_rst_n,
   input  wire         i_load,
   input  wire word_t  i_inst,
   output opcode_e     o_opcode,
   output logic [4:0]  o_rd,
   output logic [4:0]  o_rs1,
   output logic [4:0]  o_rs2,
   output logic [2:0]  o_funct3,
   output word_t       o_imm,
   output alu_fn_e     o_alu_fn,
   output logic        o_need_rs1,
   output logic        o_need_rs2,
   output logic        o_use_rs2,
   output logic        o_legal
);

   word_t      inst;
   logic [2:0] f3;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         inst <= '0;
      end else if (i_load) begin
         inst <= i_inst;
      end
   end

   assign f3       = inst[14:12];
   assign o_opcode = opcode_e'(inst[6:0]);
   assign o_rd     = inst[11:7];
   assign o_rs1    = inst[19:15];
   assign o_rs2    = inst[24:20];
   assign o_funct3 = f3;

   always_comb begin
      o_imm      = {{20{inst[31]}}, inst[31:20]};
      o_alu_fn   = ADD;
      o_need_rs1 = 1'b0;
      o_need_rs2 = 1'b0;
      o_use_rs2  = 1'b0;
      o_legal    = 1'b1;
      case (o_opcode)
         ALU_R: begin
            o_need_rs1 = 1'b1;
            o_need_rs2 = 1'b1;
            o_use_rs2  = 1'b1;
            o_alu_fn   = alu_fn_e'({inst[30] & (f3 == 3'b000 || f3 == 3'b101), f3});
         end
         ALU_I: begin
            // Bit 30 is part of the immediate except for shifts
            o_need_rs1 = 1'b1;
            o_alu_fn   = alu_fn_e'({inst[30] & (f3 == 3'b101), f3});
         end
         LOAD: begin
            o_need_rs1 = 1'b1;
         end
         STORE: begin
            o_imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            o_need_rs1 = 1'b1;
            o_need_rs2 = 1'b1;
            o_legal    = (f3 == 3'b010);
         end
         BRANCH: begin
            o_imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            o_need_rs1 = 1'b1;
            o_need_rs2 = 1'b1;
            o_use_rs2  = 1'b1;
            o_alu_fn   = f3[2] ? (f3[1] ? SLTU : SLT) : SUB;
            o_legal    = (f3[2:1] != 2'b01);
         end
         JAL: begin
            o_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         JALR: begin
            o_need_rs1 = 1'b1;
         end
         LUI: begin
            o_imm = {inst[31:12], 12'd0};
         end
         default: begin
            o_legal = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none
// ******************************
// RV32I subset core types, opcodes and boot vectors
// ******************************

package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [15:0] addr_t;

   // Supported major opcodes
   typedef enum logic [6:0] {
      ALU_R  = 7'b0110011,
      ALU_I  = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      LUI    = 7'b0110111
   } opcode_e;

   // Encoded as {inst[30], funct3}
   typedef enum logic [3:0] {
      ADD  = 4'b0000,
      SUB  = 4'b1000,
      SLL  = 4'b0001,
      SLT  = 4'b0010,
      SLTU = 4'b0011,
      XOR  = 4'b0100,
      SRL  = 4'b0101,
      SRA  = 4'b1101,
      OR   = 4'b0110,
      AND  = 4'b0111
   } alu_fn_e;

   // SP_VEC waits for the reset vector, SP_WR for the stack pointer
   typedef enum logic [3:0] {
      RESET_VEC, SP_VEC, SP_WR, FETCH, WAIT_INST, EXECUTE,
      WAIT_RS1, WAIT_RS2, WAIT_LOAD, WRITE, FAULT
   } state_e;

   localparam addr_t      VEC_RESET = 16'h0080;
   localparam addr_t      VEC_SP    = 16'h0084;
   localparam logic [4:0] SP_REG    = 5'd2;

endpackage

`default_nettype wire

// File: list.f
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_decoder.sv
hdl/rv_control.sv
hdl/rv_core.sv
tb/rv_core_chk.sv
tb/tb_rv_core.sv

// File: tb/rv_core_chk.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// Bus protocol and fault checks for rv_core
// ******************************

module rv_core_chk (
   input wire clk,
   input wire i_rst_n,
   input wire o_rd_en,
   input wire o_wr_en,
   input wire i_rd_valid,
   input wire o_fault
);

   logic outstanding;
   int   failures = 0;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         outstanding <= 1'b0;
      end else if (o_rd_en) begin
         outstanding <= 1'b1;
      end else if (i_rd_valid) begin
         outstanding <= 1'b0;
      end
   end

   a_one_enable: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_rd_en && o_wr_en))
   else begin
      failures++;
      $error("read and write enable high together");
   end

   a_rd_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_en |=> !o_rd_en)
   else begin
      failures++;
      $error("read enable high for two cycles");
   end

   a_no_overlap: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_rd_en |-> !outstanding)
   else begin
      failures++;
      $error("read issued while one is outstanding");
   end

   a_fault_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_fault |-> !(o_rd_en || o_wr_en))
   else begin
      failures++;
      $error("bus access while faulted");
   end

endmodule

bind rv_core rv_core_chk chk_i (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .o_rd_en    (o_rd_en),
   .o_wr_en    (o_wr_en),
   .i_rd_valid (i_rd_valid),
   .o_fault    (o_fault)
);

`default_nettype wire

// File: tb/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none
// ******************************
// rv_core testbench with latency-randomized memory and directed programs
// ******************************

module tb_rv_core;
   import rv_pkg::*;

   localparam addr_t PROG_BASE = 16'h0100;
   localparam word_t SP_INIT   = 32'h0000_03f0;
   // Instructions of all programs plus margin for boots and the fault idle window
   localparam int    TOTAL_INSTS = 82 + 20;
   localparam int    WATCHDOG_NS = TOTAL_INSTS * 6 * 6 * 20;

   logic  clk = 1'b0;
   logic  i_rst_n;
   logic  i_rd_valid;
   word_t i_rd_data;
   addr_t o_addr;
   logic  o_rd_en;
   logic  o_wr_en;
   word_t o_wr_data;
   logic  o_fault;

   word_t mem [0:255];
   addr_t rd_q[$];
   addr_t wr_addr_q[$];
   word_t wr_data_q[$];
   addr_t prog_pc;
   addr_t rd_addr;
   word_t lfsr = 32'hd554;
   logic  pending;
   int    cnt;
   int    errors;
   logic  b0;
   logic  b1;

   rv_core dut_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_addr     (o_addr),
      .o_rd_en    (o_rd_en),
      .i_rd_data  (i_rd_data),
      .i_rd_valid (i_rd_valid),
      .o_wr_en    (o_wr_en),
      .o_wr_data  (o_wr_data),
      .o_fault    (o_fault)
   );

   always #10 clk = ~clk;

   function automatic word_t lfsr_step(input word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Memory model answering reads and taking writes on the falling edge
   always @(negedge clk) begin
      i_rd_valid = 1'b0;
      if (!i_rst_n) begin
         pending = 1'b0;
      end else begin
         if (pending) begin
            cnt = cnt - 1;
            if (cnt == 0) begin
               i_rd_valid = 1'b1;
               i_rd_data  = mem[rd_addr[9:2]];
               pending    = 1'b0;
            end
         end
         if (o_rd_en) begin
            rd_addr = o_addr;
            rd_q.push_back(o_addr);
            b0      = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            b1      = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            cnt     = 1 + {b1, b0};
            pending = 1'b1;
         end
         if (o_wr_en) begin
            mem[o_addr[9:2]] = o_wr_data;
            wr_addr_q.push_back(o_addr);
            wr_data_q.push_back(o_wr_data);
         end
      end
   end

   function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, ALU_R};
   endfunction

   function automatic word_t i_type(input opcode_e op, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                    input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
   endfunction

   function automatic word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic word_t j_type(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
   endfunction

   function automatic word_t u_type(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, LUI};
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic put(input word_t w);
      mem[prog_pc[9:2]] = w;
      prog_pc = prog_pc + 16'd4;
   endtask

   // Registers cleared and everything else filled with an address pattern
   task automatic clear_memory();
      for (int i = 0; i < 256; i++) begin
         mem[i] = (i < 32) ? 32'd0 : {16'hc0de, 6'd0, i[7:0], 2'b00};
      end
      mem[VEC_RESET[9:2]] = {16'd0, PROG_BASE};
      mem[VEC_SP[9:2]]    = SP_INIT;
      prog_pc = PROG_BASE;
      rd_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
   endtask

   task automatic reset_core();
      @(negedge clk);
      i_rst_n = 1'b0;
      repeat (2) @(negedge clk);
      i_rst_n = 1'b1;
   endtask

   // Appends the self-jump and runs until it is fetched
   task automatic run_program();
      addr_t halt_pc;
      halt_pc = prog_pc;
      put(j_type(5'd0, 21'd0));
      reset_core();
      do @(negedge clk); while (!(o_rd_en && o_addr == halt_pc));
   endtask

   task automatic scan_for_x0_writes();
      foreach (wr_addr_q[i]) begin
         if (wr_addr_q[i] == 16'd0) begin
            errors++;
            $display("register x0 was written");
         end
      end
   endtask

   task automatic boot_vectors();
      clear_memory();
      put(i_type(ALU_I, 3'b000, 5'd0, 5'd0, 12'h000));
      run_program();
      check_addr("first read", rd_q[0], VEC_RESET);
      check_addr("second read", rd_q[1], VEC_SP);
      check_addr("first fetch", rd_q[2], PROG_BASE);
      check_addr("first write", wr_addr_q[0], addr_t'(4 * SP_REG));
      check_word("first write data", wr_data_q[0], SP_INIT);
      check_word("x2", mem[SP_REG], SP_INIT);
   endtask

   task automatic alu_ops();
      clear_memory();
      put(i_type(ALU_I, 3'b000, 5'd1, 5'd0, 12'hff9));
      put(i_type(ALU_I, 3'b000, 5'd3, 5'd0, 12'h003));
      put(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd3));
      put(r_type(7'h20, 3'b000, 5'd5, 5'd3, 5'd1));
      put(r_type(7'h20, 3'b101, 5'd6, 5'd1, 5'd3));
      put(r_type(7'h00, 3'b101, 5'd7, 5'd1, 5'd3));
      put(r_type(7'h00, 3'b001, 5'd8, 5'd3, 5'd3));
      put(r_type(7'h00, 3'b010, 5'd9, 5'd1, 5'd3));
      put(r_type(7'h00, 3'b011, 5'd10, 5'd1, 5'd3));
      put(i_type(ALU_I, 3'b100, 5'd11, 5'd1, 12'h0f0));
      put(i_type(ALU_I, 3'b110, 5'd12, 5'd3, 12'hff0));
      put(i_type(ALU_I, 3'b111, 5'd13, 5'd1, 12'h07f));
      put(i_type(ALU_I, 3'b101, 5'd14, 5'd1, 12'h401));
      put(i_type(ALU_I, 3'b010, 5'd15, 5'd1, 12'hffa));
      put(i_type(ALU_I, 3'b011, 5'd16, 5'd3, 12'hfff));
      put(i_type(ALU_I, 3'b000, 5'd0, 5'd3, 12'h005));
      run_program();
      check_word("x1", mem[1], 32'hffff_fff9);
      check_word("x4 add", mem[4], 32'hffff_fffc);
      check_word("x5 sub", mem[5], 32'h0000_000a);
      check_word("x6 sra", mem[6], 32'hffff_ffff);
      check_word("x7 srl", mem[7], 32'h1fff_ffff);
      check_word("x8 sll", mem[8], 32'h0000_0018);
      check_word("x9 slt", mem[9], 32'h0000_0001);
      check_word("x10 sltu", mem[10], 32'h0000_0000);
      check_word("x11 xori", mem[11], 32'hffff_ff09);
      check_word("x12 ori", mem[12], 32'hffff_fff3);
      check_word("x13 andi", mem[13], 32'h0000_0079);
      check_word("x14 srai", mem[14], 32'hffff_fffc);
      check_word("x15 slti", mem[15], 32'h0000_0001);
      check_word("x16 sltiu", mem[16], 32'h0000_0001);
      check_word("x0", mem[0], 32'h0);
      scan_for_x0_writes();
   endtask

   task automatic loads_and_stores();
      clear_memory();
      put(i_type(ALU_I, 3'b000, 5'd1, 5'd0, 12'h200));
      put(u_type(5'd3, 20'h87654));
      put(i_type(ALU_I, 3'b000, 5'd3, 5'd3, 12'h321));
      put(s_type(5'd3, 5'd1, 12'h004));
      put(i_type(LOAD, 3'b000, 5'd4, 5'd1, 12'h005));
      put(i_type(LOAD, 3'b000, 5'd5, 5'd1, 12'h007));
      put(i_type(LOAD, 3'b100, 5'd6, 5'd1, 12'h007));
      put(i_type(LOAD, 3'b001, 5'd7, 5'd1, 12'h006));
      put(i_type(LOAD, 3'b101, 5'd8, 5'd1, 12'h006));
      put(i_type(LOAD, 3'b001, 5'd9, 5'd1, 12'h004));
      put(i_type(LOAD, 3'b010, 5'd10, 5'd1, 12'h004));
      run_program();
      check_word("mem 0x204", mem[129], 32'h8765_4321);
      check_word("x4 lb", mem[4], 32'h0000_0043);
      check_word("x5 lb", mem[5], 32'hffff_ff87);
      check_word("x6 lbu", mem[6], 32'h0000_0087);
      check_word("x7 lh", mem[7], 32'hffff_8765);
      check_word("x8 lhu", mem[8], 32'h0000_8765);
      check_word("x9 lh", mem[9], 32'h0000_4321);
      check_word("x10 lw", mem[10], 32'h8765_4321);
   endtask

   task automatic upper_immediate();
      clear_memory();
      put(u_type(5'd1, 20'h12345));
      put(u_type(5'd3, 20'hfffff));
      run_program();
      check_word("x1 lui", mem[1], 32'h1234_5000);
      check_word("x3 lui", mem[3], 32'hffff_f000);
   endtask

   // Marker ends at 2 when the branch is taken and at 3 when it is not
   task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [4:0] rd);
      put(b_type(f3, rs1, rs2, 13'd8));
      put(i_type(ALU_I, 3'b000, rd, 5'd0, 12'h001));
      put(i_type(ALU_I, 3'b000, rd, rd, 12'h002));
   endtask

   task automatic branches_and_jumps();
      addr_t p;
      clear_memory();
      put(i_type(ALU_I, 3'b000, 5'd1, 5'd0, 12'h005));
      put(i_type(ALU_I, 3'b000, 5'd3, 5'd0, 12'hffd));
      branch_case(3'b000, 5'd1, 5'd1, 5'd10);
      branch_case(3'b000, 5'd1, 5'd3, 5'd11);
      branch_case(3'b001, 5'd1, 5'd3, 5'd12);
      branch_case(3'b001, 5'd1, 5'd1, 5'd13);
      branch_case(3'b100, 5'd3, 5'd1, 5'd14);
      branch_case(3'b100, 5'd1, 5'd3, 5'd15);
      branch_case(3'b101, 5'd1, 5'd3, 5'd16);
      branch_case(3'b101, 5'd3, 5'd1, 5'd17);
      branch_case(3'b110, 5'd1, 5'd3, 5'd18);
      branch_case(3'b110, 5'd3, 5'd1, 5'd19);
      branch_case(3'b111, 5'd3, 5'd1, 5'd20);
      branch_case(3'b111, 5'd1, 5'd3, 5'd21);
      p = prog_pc;
      put(j_type(5'd22, 21'd8));
      put(i_type(ALU_I, 3'b000, 5'd23, 5'd0, 12'h001));
      put(i_type(ALU_I, 3'b000, 5'd24, 5'd0, p[11:0] + 12'd24));
      // Target offset is odd so that bit 0 must be cleared
      put(i_type(JALR, 3'b000, 5'd25, 5'd24, 12'h001));
      put(i_type(ALU_I, 3'b000, 5'd26, 5'd0, 12'h001));
      put(i_type(ALU_I, 3'b000, 5'd26, 5'd0, 12'h002));
      put(i_type(ALU_I, 3'b000, 5'd27, 5'd0, 12'h007));
      run_program();
      for (int i = 0; i < 12; i++) begin
         check_word($sformatf("x%0d marker", 10 + i), mem[10 + i], (i % 2 == 0) ? 2 : 3);
      end
      check_word("x22 jal link", mem[22], {16'd0, p + 16'd4});
      check_word("x23 skipped", mem[23], 32'd0);
      check_word("x25 jalr link", mem[25], {16'd0, p + 16'd16});
      check_word("x26 skipped", mem[26], 32'd0);
      check_word("x27 target", mem[27], 32'd7);
   endtask

   task automatic illegal_opcode();
      int accesses;
      clear_memory();
      accesses = 0;
      put(i_type(ALU_I, 3'b000, 5'd1, 5'd0, 12'h001));
      put(32'h0000_007f);
      reset_core();
      do @(negedge clk); while (!o_fault);
      repeat (50) begin
         @(negedge clk);
         if (o_rd_en || o_wr_en || !o_fault) begin
            accesses++;
         end
      end
      if (accesses != 0) begin
         errors++;
         $display("core left the fault state or accessed the bus after the fault");
      end
      check_word("x1 before fault", mem[1], 32'd1);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout, program did not finish");
      $display("tests failed");
      $finish;
   end

   initial begin
      i_rst_n    = 1'b0;
      i_rd_valid = 1'b0;
      i_rd_data  = '0;
      pending    = 1'b0;
      errors     = 0;
      boot_vectors();
      alu_ops();
      loads_and_stores();
      upper_immediate();
      branches_and_jumps();
      illegal_opcode();
      $display("%0d check errors, %0d assertion errors", errors, dut_i.chk_i.failures);
      if (errors == 0 && dut_i.chk_i.failures == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
